/* hdl/rn_pkg.sv */
package rn_pkg;

   parameter int NUM_LREGS = 32;   // Architectural registers
   parameter int NUM_PREGS = 64;   // Physical register file size

   typedef logic [4:0]  reg_addr_t;   // Logical register number
   typedef logic [5:0]  prf_addr_t;   // Physical register number
   typedef logic [7:0]  opc_t;        // Opaque to rename
   typedef logic [31:0] pc_t;
   typedef logic [31:0] data_t;

   // Decoded micro-op as handed over by decode
   typedef struct packed {
      opc_t      opc;
      pc_t       pc;
      data_t     imm;
      reg_addr_t lrs1;
      reg_addr_t lrs2;
      reg_addr_t lrd;
      logic      lrd_we;    // Micro-op writes a destination
   } rn_uop_t;

   // One retiring micro-op from the ROB
   typedef struct packed {
      logic      valid;
      reg_addr_t lrd;
      prf_addr_t prd;       // New mapping, becomes architectural
      prf_addr_t pfree;     // Old mapping, back to free list
      logic      prd_we;
   } rn_commit_t;

endpackage

/* hdl/rn_fl.sv */
`timescale 1ns/100ps

module rn_fl (
   input  logic               clk,
   input  logic               rst,
   input  logic               ren_we,
   input  logic               rollback,
   input  rn_pkg::rn_commit_t commit,
   output rn_pkg::prf_addr_t  fl_prd,
   output logic               fl_empty
);

   // Physical registers beyond the architectural set start out free
   localparam int FL_DEPTH = rn_pkg::NUM_PREGS - rn_pkg::NUM_LREGS;
   localparam int FL_AW    = $clog2(FL_DEPTH);

   typedef logic [FL_AW:0] fl_ptr_t;   // MSB is the wrap bit

   rn_pkg::prf_addr_t fl_mem [FL_DEPTH];

   fl_ptr_t spec_head;      // Next register given to rename
   fl_ptr_t cmt_head;       // Head as the committed state sees it
   fl_ptr_t tail;           // Next push slot
   fl_ptr_t cmt_head_nxt;   // Committed head after this cycle's commit
   logic    push;

   assign push = commit.valid & commit.prd_we;
   assign cmt_head_nxt = push ? cmt_head + fl_ptr_t'(1) : cmt_head;

   // Head entry offered combinationally
   assign fl_prd = fl_mem[spec_head[FL_AW-1:0]];

   // Same slot and same wrap means nothing left to hand out
   assign fl_empty = (spec_head == tail);

   // Storage
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < FL_DEPTH; i++) begin
            fl_mem[i] <= rn_pkg::prf_addr_t'(rn_pkg::NUM_LREGS + i);   // 32..63 in order
         end
      end else if (push) begin
         fl_mem[tail[FL_AW-1:0]] <= commit.pfree;   // Old mapping is dead now
      end
   end

   // Pointers
   always_ff @(posedge clk) begin
      if (rst) begin
         spec_head <= '0;
         cmt_head  <= '0;
         tail      <= fl_ptr_t'(FL_DEPTH);   // Full after reset
      end else begin
         cmt_head <= cmt_head_nxt;
         if (push) begin
            tail <= tail + fl_ptr_t'(1);
         end
         // Rollback hands back everything popped past the committed head
         if (rollback) begin
            spec_head <= cmt_head_nxt;
         end else if (ren_we) begin
            spec_head <= spec_head + fl_ptr_t'(1);
         end
      end
   end

   // Committed head trails the speculative head, and the tail stays
   // one full depth ahead of it, so a push never overwrites a live entry

endmodule

/* hdl/rn_rat.sv */
`timescale 1ns/100ps

module rn_rat (
   input  logic               clk,
   input  logic               rst,
   input  logic               ren_we,
   input  logic               rollback,
   input  rn_pkg::reg_addr_t  lrs1,
   input  rn_pkg::reg_addr_t  lrs2,
   input  rn_pkg::reg_addr_t  lrd,
   input  rn_pkg::prf_addr_t  fl_prd,
   input  rn_pkg::rn_commit_t commit,
   output rn_pkg::prf_addr_t  prs1,
   output rn_pkg::prf_addr_t  prs2,
   output rn_pkg::prf_addr_t  pold
);

   localparam int NL = rn_pkg::NUM_LREGS;

   rn_pkg::prf_addr_t spec_tbl [NL];   // Speculative map, used by rename
   rn_pkg::prf_addr_t arch_tbl [NL];   // Committed map
   rn_pkg::prf_addr_t arch_nxt [NL];   // Committed map after this cycle
   logic              cmt_we;

   assign cmt_we = commit.valid & commit.prd_we;

   // Rename lookups from the speculative map
   assign prs1 = spec_tbl[lrs1];
   assign prs2 = spec_tbl[lrs2];
   assign pold = spec_tbl[lrd];   // Read before this edge's write

   // Architectural table with the commit folded in
   always_comb begin
      arch_nxt = arch_tbl;
      if (cmt_we) begin
         arch_nxt[commit.lrd] = commit.prd;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NL; i++) begin
            arch_tbl[i] <= rn_pkg::prf_addr_t'(i);   // Identity
         end
      end else begin
         arch_tbl <= arch_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NL; i++) begin
            spec_tbl[i] <= rn_pkg::prf_addr_t'(i);
         end
      end else if (rollback) begin
         // Whole table back to committed view in one edge
         // Includes a commit landing this same cycle
         spec_tbl <= arch_nxt;
      end else if (ren_we) begin
         spec_tbl[lrd] <= fl_prd;   // New mapping from free list head
      end
   end

   // Rename is stalled under rollback, so the two write paths
   // into the speculative table never meet on one edge

   // Logical 0 is filtered upstream, its entry stays at physical 0

endmodule

/* hdl/rn_rob_alloc.sv */
`timescale 1ns/100ps

module rn_rob_alloc #(
   parameter int ROB_AW = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              alloc,
   input  logic              commit_valid,
   input  logic              rollback,
   output logic [ROB_AW-1:0] rob_id,
   output logic              rob_full
);

   logic [ROB_AW-1:0] head;       // Oldest uncommitted slot
   logic [ROB_AW-1:0] tail;       // Next slot to hand out
   logic [ROB_AW-1:0] head_nxt;
   logic [ROB_AW:0]   cnt;        // Slots in flight, 0..2**ROB_AW
   logic              alloc_ok;
   logic              free_ok;

   assign alloc_ok = alloc & ~rob_full;
   assign free_ok  = commit_valid & (cnt != '0);   // Ignore commit on empty ROB
   assign head_nxt = free_ok ? head + ROB_AW'(1) : head;

   assign rob_id   = tail;
   assign rob_full = cnt[ROB_AW];   // MSB only set at full depth

   always_ff @(posedge clk) begin
      if (rst) begin
         head <= '0;
         tail <= '0;
         cnt  <= '0;
      end else begin
         head <= head_nxt;
         if (rollback) begin
            tail <= head_nxt;   // Drop all uncommitted slots
            cnt  <= '0;
         end else begin
            if (alloc_ok) begin
               tail <= tail + ROB_AW'(1);   // Wraps modulo depth
            end
            case ({alloc_ok, free_ok})
               2'b10:   cnt <= cnt + (ROB_AW+1)'(1);
               2'b01:   cnt <= cnt - (ROB_AW+1)'(1);
               default: cnt <= cnt;   // Both or neither
            endcase
         end
      end
   end

endmodule

/* hdl/rn.sv */
`timescale 1ns/100ps

module rn #(
   parameter int ROB_AW = 4
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               rn_valid,
   input  rn_pkg::rn_uop_t    rn_uop,
   output logic               rn_stall_req,
   input  logic               issue_ready,
   input  logic               rollback,
   input  rn_pkg::rn_commit_t commit,
   output logic               issue_push,
   output rn_pkg::rn_uop_t    issue_uop,
   output rn_pkg::prf_addr_t  issue_prs1,
   output rn_pkg::prf_addr_t  issue_prs2,
   output rn_pkg::prf_addr_t  issue_prd,
   output rn_pkg::prf_addr_t  issue_pfree,
   output logic               issue_prd_we,
   output logic [ROB_AW-1:0]  issue_rob_id
);

   rn_pkg::prf_addr_t fl_prd;
   rn_pkg::prf_addr_t prs1;
   rn_pkg::prf_addr_t prs2;
   rn_pkg::prf_addr_t pold;
   logic              fl_empty;
   logic              rob_full;
   logic [ROB_AW-1:0] rob_id;
   logic              needs_rd;   // Destination to rename, r0 excluded
   logic              accept;
   logic              ren_we;

   assign needs_rd = rn_uop.lrd_we & (rn_uop.lrd != '0);

   // Any resource short or a flush in progress
   assign rn_stall_req = (fl_empty & needs_rd) | rob_full | ~issue_ready | rollback;

   assign accept = rn_valid & ~rn_stall_req;
   assign ren_we = accept & needs_rd;   // Shared by free list and map table

   rn_fl u_rn_fl (
      .clk      (clk),
      .rst      (rst),
      .ren_we   (ren_we),
      .rollback (rollback),
      .commit   (commit),
      .fl_prd   (fl_prd),
      .fl_empty (fl_empty)
   );

   rn_rat u_rn_rat (
      .clk      (clk),
      .rst      (rst),
      .ren_we   (ren_we),
      .rollback (rollback),
      .lrs1     (rn_uop.lrs1),
      .lrs2     (rn_uop.lrs2),
      .lrd      (rn_uop.lrd),
      .fl_prd   (fl_prd),
      .commit   (commit),
      .prs1     (prs1),
      .prs2     (prs2),
      .pold     (pold)
   );

   rn_rob_alloc #(
      .ROB_AW (ROB_AW)
   ) u_rn_rob_alloc (
      .clk          (clk),
      .rst          (rst),
      .alloc        (accept),   // Every accepted uop takes a slot
      .commit_valid (commit.valid),
      .rollback     (rollback),
      .rob_id       (rob_id),
      .rob_full     (rob_full)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         issue_push <= 1'b0;
      end else begin
         issue_push <= accept;   // One cycle per accepted uop
      end
   end

   // Payload only loads on accept
   always_ff @(posedge clk) begin
      if (accept) begin
         issue_uop    <= rn_uop;
         issue_prs1   <= prs1;
         issue_prs2   <= prs2;
         issue_prd    <= fl_prd;   // Don't care when prd_we is low
         issue_prd_we <= ren_we;
         issue_pfree  <= pold;     // Freed when this uop commits
         issue_rob_id <= rob_id;
      end
   end

endmodule

/* verification/tb_rn.sv */
`timescale 1ns/100ps

module tb_rn;

   localparam int ROB_AW   = 4;
   localparam int WAIT_MAX = 40;   // Cycles a rename may stay stalled

   typedef logic [ROB_AW-1:0] rob_id_t;

   logic                 clk;
   logic                 rst;
   logic                 rn_valid;
   rn_pkg::rn_uop_t      rn_uop;
   logic                 rn_stall_req;
   logic                 issue_ready;
   logic                 rollback;
   rn_pkg::rn_commit_t   commit;
   logic                 issue_push;
   rn_pkg::rn_uop_t      issue_uop;
   rn_pkg::prf_addr_t    issue_prs1;
   rn_pkg::prf_addr_t    issue_prs2;
   rn_pkg::prf_addr_t    issue_prd;
   rn_pkg::prf_addr_t    issue_pfree;
   logic                 issue_prd_we;
   rob_id_t              issue_rob_id;

   rn #(
      .ROB_AW (ROB_AW)
   ) u_rn (
      .clk          (clk),
      .rst          (rst),
      .rn_valid     (rn_valid),
      .rn_uop       (rn_uop),
      .rn_stall_req (rn_stall_req),
      .issue_ready  (issue_ready),
      .rollback     (rollback),
      .commit       (commit),
      .issue_push   (issue_push),
      .issue_uop    (issue_uop),
      .issue_prs1   (issue_prs1),
      .issue_prs2   (issue_prs2),
      .issue_prd    (issue_prd),
      .issue_pfree  (issue_pfree),
      .issue_prd_we (issue_prd_we),
      .issue_rob_id (issue_rob_id)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   task automatic fail_now(input string msg);
      $display(">>> FAIL");
      $display("%s", msg);
      $fatal(1, "run stopped");
   endtask

   task automatic check_prf(input string name, input rn_pkg::prf_addr_t got,
                            input rn_pkg::prf_addr_t exp);
      if (got !== exp) fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_rob_id(input string name, input rob_id_t got, input rob_id_t exp);
      if (got !== exp) fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   task automatic check_uop(input string name, input rn_pkg::rn_uop_t got,
                            input rn_pkg::rn_uop_t exp);
      if (got !== exp) fail_now($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // Payload fields only tag the step and pass through rename unchanged
   function automatic rn_pkg::rn_uop_t make_uop(input int lrs1, input int lrs2, input int lrd,
                                                 input int we, input int tag);
      rn_pkg::rn_uop_t u;
      u.opc    = rn_pkg::opc_t'(tag);
      u.pc     = rn_pkg::pc_t'(32'h1000 + tag * 4);
      u.imm    = rn_pkg::data_t'(tag);
      u.lrs1   = rn_pkg::reg_addr_t'(lrs1);
      u.lrs2   = rn_pkg::reg_addr_t'(lrs2);
      u.lrd    = rn_pkg::reg_addr_t'(lrd);
      u.lrd_we = (we != 0);
      return u;
   endfunction

   // Present one uop, optionally under back-pressure, and check the issue slot
   task automatic rename_uop(input rn_pkg::rn_uop_t uop, input int hold,
                             input rn_pkg::prf_addr_t e_prs1, input rn_pkg::prf_addr_t e_prs2,
                             input logic e_we, input rn_pkg::prf_addr_t e_prd,
                             input rn_pkg::prf_addr_t e_pfree, input rob_id_t e_rob,
                             input logic chk_pfree);
      int tmo;
      @(negedge clk);
      rn_valid    = 1'b1;
      rn_uop      = uop;
      issue_ready = (hold == 0);
      for (int i = 0; i < hold; i++) begin
         #1;
         check_bit("rn_stall_req", rn_stall_req, 1'b1);   // Held by issue_ready
         check_bit("issue_push", issue_push, 1'b0);
         @(negedge clk);
      end
      issue_ready = 1'b1;
      tmo = 0;
      #1;
      while (rn_stall_req) begin
         tmo++;
         if (tmo > WAIT_MAX) fail_now("rename was never accepted, stall stayed high");
         @(negedge clk);
         #1;
      end
      @(negedge clk);   // Accepted on the edge in between
      rn_valid = 1'b0;
      check_bit("issue_push", issue_push, 1'b1);
      check_uop("issue_uop", issue_uop, uop);
      check_prf("issue_prs1", issue_prs1, e_prs1);
      check_prf("issue_prs2", issue_prs2, e_prs2);
      check_bit("issue_prd_we", issue_prd_we, e_we);
      if (e_we) check_prf("issue_prd", issue_prd, e_prd);
      if (e_we && chk_pfree) check_prf("issue_pfree", issue_pfree, e_pfree);
      check_rob_id("issue_rob_id", issue_rob_id, e_rob);
      @(negedge clk);
      #1;
      check_bit("issue_push", issue_push, 1'b0);   // Single cycle pulse
   endtask

   // A stalled uop stays offered across one edge and must not issue
   task automatic probe_stall(input rn_pkg::rn_uop_t uop, input logic e_stall);
      @(negedge clk);
      rn_valid = e_stall;
      rn_uop   = uop;
      #1;
      check_bit("rn_stall_req", rn_stall_req, e_stall);
      @(negedge clk);
      rn_valid = 1'b0;
      #1;
      check_bit("issue_push", issue_push, 1'b0);
   endtask

   task automatic send_commit(input int lrd, input int prd, input int pfree, input int we);
      @(negedge clk);
      commit.valid  = 1'b1;
      commit.lrd    = rn_pkg::reg_addr_t'(lrd);
      commit.prd    = rn_pkg::prf_addr_t'(prd);
      commit.pfree  = rn_pkg::prf_addr_t'(pfree);
      commit.prd_we = (we != 0);
      @(negedge clk);
      commit = '0;
   endtask

   task automatic pulse_rollback();
      @(negedge clk);
      rollback = 1'b1;
      @(negedge clk);
      rollback = 1'b0;
   endtask

   initial begin
      int    fd;
      int    n;
      int    cnt;
      int    hold;
      int    step;
      byte   op;
      int    f0, f1, f2, f3, f4, f5, f6, f7, f8, f9;
      string line;
      void'($urandom(32'h8e71f361));
      rst         = 1'b1;
      rn_valid    = 1'b0;
      rn_uop      = '0;
      issue_ready = 1'b1;
      rollback    = 1'b0;
      commit      = '0;
      hold        = 0;
      step        = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      #1;
      check_bit("rn_stall_req", rn_stall_req, 1'b0);   // Idle after reset
      check_bit("issue_push", issue_push, 1'b0);
      fd = $fopen("verification/rn_trace.txt", "r");
      if (fd == 0) fail_now("cannot open the trace file");
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n == 0) break;
         if (line.len() < 2 || line[0] == "#") continue;   // Blank or comment
         cnt = $sscanf(line, "%c %d %d %d %d %d %d %d %d %d %d",
                       op, f0, f1, f2, f3, f4, f5, f6, f7, f8, f9);
         step++;
         case (op)
            "R": begin
               if (cnt != 11) fail_now($sformatf("trace step %0d has wrong field count", step));
               rename_uop(make_uop(f0, f1, f2, f3, step), hold,
                          rn_pkg::prf_addr_t'(f4), rn_pkg::prf_addr_t'(f5), f6[0],
                          rn_pkg::prf_addr_t'(f7), rn_pkg::prf_addr_t'(f8),
                          rob_id_t'(f9), 1'b1);
               hold = 0;
            end
            "M": begin   // Burst with consecutive prd and ROB ids in FIFO order
               for (int i = 0; i < f0; i++) begin
                  rename_uop(make_uop(0, 0, f1, 1, step), 0, '0, '0, (f1 != 0),
                             rn_pkg::prf_addr_t'(f2 + i), '0, rob_id_t'(f3 + i), 1'b0);
               end
            end
            "S": probe_stall(make_uop(f0, f1, f2, f3, step), f4[0]);
            "C": send_commit(f0, f1, f2, f3);
            "K": begin   // Retire ROB slots only
               for (int i = 0; i < f0; i++) begin
                  send_commit(0, 0, 0, 0);
               end
            end
            "B": pulse_rollback();
            "H": hold = f0;   // Back-pressure for the next rename
            default: fail_now($sformatf("unknown operation in trace step %0d", step));
         endcase
         repeat ($urandom % 3) @(negedge clk);   // Idle gap
      end
      $fclose(fd);
      $display(">>> PASS");
      $finish;
   end

endmodule

/* verification/rn_trace.txt */
# R lrs1 lrs2 lrd lrd_we | prs1 prs2 prd_we prd pfree rob_id   C lrd prd pfree prd_we
# S lrs1 lrs2 lrd lrd_we stall   M count lrd prd0 rob0   K count   H cycles   B rollback
R 3 4 1 1 3 4 1 32 1 0
R 5 6 2 1 5 6 1 33 2 1
R 1 2 0 1 32 33 0 0 0 2
R 1 0 3 1 32 0 1 34 3 3
C 1 32 1 1
C 2 33 2 1
C 0 0 0 0
C 3 34 3 1
# drain the free list, ROB slots retired without register pushes
M 14 5 35 4
K 14
M 15 5 49 2
K 15
R 0 0 6 1 0 0 1 1 6 1
R 0 0 7 1 0 0 1 2 7 2
R 0 0 8 1 0 0 1 3 8 3
S 0 0 9 1 1
S 0 0 0 0 0
C 6 1 6 1
R 6 5 9 1 1 63 1 6 9 4
# rollback to committed state
B
R 6 1 5 1 1 32 1 36 5 2
H 3
R 5 9 10 1 36 9 1 37 10 3
C 5 36 5 1
C 10 37 10 1
# move the ROB tail to slot 0, then fill all sixteen slots
M 12 0 0 4
K 12
M 16 11 38 0
S 0 0 0 0 1
C 11 38 11 1
R 11 0 12 1 53 0 1 54 12 0

/* sim.f */
hdl/rn_pkg.sv
hdl/rn_fl.sv
hdl/rn_rat.sv
hdl/rn_rob_alloc.sv
hdl/rn.sv
verification/tb_rn.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_rn -Mdir obj_dir

./obj_dir/Vtb_rn
